// File: hdl/texConfigPkg.sv
package texConfigPkg;

    // Largest texture side is 2**maxSizeLog2 texels
    localparam int maxSizeLog2 = 5;

    // 2048 words hold a full 32x32 mip chain (1365 words)
    localparam int memAddrWidth = 11;

    // Raw 16-bit texel word, no format conversion
    localparam int texelWidth = 16;

    // Wrap behaviour per axis
    typedef enum logic
    {
        wrapRepeat = 1'b0,
        wrapClamp = 1'b1
    } wrapMode_t;

    // Texture geometry as seen by the sampler
    typedef struct packed
    {
        // Side lengths as log2, valid 0..maxSizeLog2
        logic [3:0] widthLog2;
        logic [3:0] heightLog2;
        // Wrap mode for the s and t axes
        wrapMode_t wrapS;
        wrapMode_t wrapT;
    } texConfig_t;

endpackage

// File: hdl/texPipePkg.sv
package texPipePkg;

    import texConfigPkg::*;

    // Signed fixed point, 1 sign bit, 16 integer bits, 15 fraction bits
    typedef logic signed [31:0] fixed_t;

    // One fragment request
    typedef struct packed
    {
        // Coordinates of the rendered fragment
        fixed_t s;
        fixed_t t;
        // Coordinates of the neighbour one step in x and in y
        fixed_t sXy;
        fixed_t tXy;
        // Geometry and wrap modes of the bound texture
        texConfig_t cfg;
    } texRequest_t;

    // Output of the LOD stage
    typedef struct packed
    {
        // Request passed along unchanged
        texRequest_t req;
        // Raw LOD, 0..8, not yet clamped to the texture
        logic [3:0] lod;
    } lodStage_t;

    // Address stage output and final sampler result
    typedef struct packed
    {
        // Mip level actually used
        logic [3:0] level;
        // Word address inside the packed chain
        logic [memAddrWidth-1:0] addr;
        // Texel word, zero until the memory stage
        logic [texelWidth-1:0] data;
    } texResult_t;

endpackage

// File: hdl/lodCalculator.sv
`timescale 1ns/1ps

// LOD from a fragment and its diagonal neighbour
//
//  fragment  | .
//  .         | neighbour (x+1, y+1)
//
// One cycle deep, one request per clock
module lodCalculator
(
    input  logic                    aclk,
    input  logic                    rstN,
    input  logic                    reqValid,
    input  texPipePkg::texRequest_t req,
    output logic                    lodValid,
    output texPipePkg::lodStage_t   lodOut
);
    import texPipePkg::*;

    fixed_t diffS;
    fixed_t diffT;
    logic [14:0] magS;
    logic [14:0] magT;
    logic [7:0] scaledS;
    logic [7:0] scaledT;
    logic [7:0] diffMax;
    logic [3:0] lodNext;

    always_comb
    begin
        // Screen-space step of each coordinate
        diffS = req.s - req.sXy;
        diffT = req.t - req.tXy;
        // Magnitude, only the fraction part matters
        magS = diffS[31] ? 15'(-diffS) : diffS[14:0];
        magT = diffT[31] ? 15'(-diffT) : diffT[14:0];
        // Top 8 fraction bits, scaled to texels of the base level
        scaledS = magS[14:7] >> (4'd8 - req.cfg.widthLog2);
        scaledT = magT[14:7] >> (4'd8 - req.cfg.heightLog2);
        // OR approximates the larger of the two steps
        diffMax = scaledS | scaledT;

        // Highest set bit plus one
        casez (diffMax)
            8'b1???????: lodNext = 4'd8;
            8'b01??????: lodNext = 4'd7;
            8'b001?????: lodNext = 4'd6;
            8'b0001????: lodNext = 4'd5;
            8'b00001???: lodNext = 4'd4;
            8'b000001??: lodNext = 4'd3;
            8'b0000001?: lodNext = 4'd2;
            8'b00000001: lodNext = 4'd1;
            default:     lodNext = 4'd0;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!rstN)
            lodValid <= 1'b0;
        else
            lodValid <= reqValid;
    end

    // Payload travels alongside the valid bit
    always_ff @(posedge aclk)
    begin
        lodOut.req <= req;
        lodOut.lod <= lodNext;
    end

endmodule

// File: hdl/texelAddressGen.sv
`timescale 1ns/1ps

// Level clamp, wrap and mip-chain address
// Chain layout is level 0 first, each level packed row by row
module texelAddressGen
(
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   lodValid,
    input  texPipePkg::lodStage_t  lodIn,
    output logic                   addrValid,
    output texPipePkg::texResult_t addrOut
);
    import texConfigPkg::*;
    import texPipePkg::*;

    logic [3:0] maxLevel;
    logic [3:0] level;
    logic [3:0] levelWLog2;
    logic [3:0] levelHLog2;
    logic [maxSizeLog2-1:0] u;
    logic [maxSizeLog2-1:0] v;
    logic [memAddrWidth-1:0] levelOffset;
    logic [memAddrWidth-1:0] rowBase;
    logic [memAddrWidth-1:0] addrNext;

    // Side log2 at a given level, floored at one texel
    function automatic logic [3:0] floorSub(input logic [3:0] sizeLog2, input logic [3:0] lvl);
        return (sizeLog2 > lvl) ? sizeLog2 - lvl : 4'd0;
    endfunction

    // Coordinate to texel index on one axis
    function automatic logic [maxSizeLog2-1:0] wrapCoord(
        input fixed_t     coord,
        input wrapMode_t  mode,
        input logic [3:0] sizeLog2
    );
        logic [maxSizeLog2-1:0] frac;
        logic [maxSizeLog2-1:0] edgeMax;
        // Top sizeLog2 fraction bits give the index
        frac = coord[14 -: maxSizeLog2] >> (maxSizeLog2 - sizeLog2);
        edgeMax = maxSizeLog2'((32'd1 << sizeLog2) - 32'd1);
        if (mode == wrapRepeat)
            return frac;
        // Clamp to edge
        if (coord[31])
            return '0;
        if (coord[30:15] != '0)
            return edgeMax;
        return frac;
    endfunction

    always_comb
    begin
        maxLevel = (lodIn.req.cfg.widthLog2 > lodIn.req.cfg.heightLog2)
            ? lodIn.req.cfg.widthLog2 : lodIn.req.cfg.heightLog2;
        // Never go past the 1x1 level
        level = (lodIn.lod < maxLevel) ? lodIn.lod : maxLevel;
        levelWLog2 = floorSub(lodIn.req.cfg.widthLog2, level);
        levelHLog2 = floorSub(lodIn.req.cfg.heightLog2, level);

        u = wrapCoord(lodIn.req.s, lodIn.req.cfg.wrapS, levelWLog2);
        v = wrapCoord(lodIn.req.t, lodIn.req.cfg.wrapT, levelHLog2);

        // Sum of word counts of every level below the selected one
        levelOffset = '0;
        for (int k = 0; k < maxSizeLog2; k++)
        begin
            if (k < level)
                levelOffset = levelOffset + (memAddrWidth'(1) <<
                    (floorSub(lodIn.req.cfg.widthLog2, 4'(k)) +
                     floorSub(lodIn.req.cfg.heightLog2, 4'(k))));
        end

        // Row start inside the level
        rowBase = memAddrWidth'(v) << levelWLog2;
        addrNext = levelOffset + rowBase + memAddrWidth'(u);
    end

    always_ff @(posedge aclk)
    begin
        if (!rstN)
            addrValid <= 1'b0;
        else
            addrValid <= lodValid;
    end

    always_ff @(posedge aclk)
    begin
        addrOut.level <= level;
        addrOut.addr <= addrNext;
        // Filled in by the memory stage
        addrOut.data <= '0;
    end

endmodule

// File: hdl/textureMemory.sv
`timescale 1ns/1ps

// Texel RAM with a load port and a registered read
// Same-cycle write and read of one word returns the old word
module textureMemory
(
    input  logic                                aclk,
    input  logic                                rstN,
    input  logic                                memWrite,
    input  logic [texConfigPkg::memAddrWidth-1:0] memAddr,
    input  logic [texConfigPkg::texelWidth-1:0]   memData,
    input  logic                                addrValid,
    input  texPipePkg::texResult_t              addrIn,
    output logic                                texelValid,
    output texPipePkg::texResult_t              texel
);
    import texConfigPkg::*;

    logic [texelWidth-1:0] mem [2**memAddrWidth];

    // Load port
    always_ff @(posedge aclk)
    begin
        if (memWrite)
            mem[memAddr] <= memData;
    end

    // Read and forward the record with data filled in
    always_ff @(posedge aclk)
    begin
        texel.level <= addrIn.level;
        texel.addr <= addrIn.addr;
        texel.data <= mem[addrIn.addr];
    end

    always_ff @(posedge aclk)
    begin
        if (!rstN)
            texelValid <= 1'b0;
        else
            texelValid <= addrValid;
    end

endmodule

// File: hdl/textureSampler.sv
`timescale 1ns/1ps

// Texture fetch front end
// Request to texel in three cycles, nearest texel only
//
//  req -> lodCalculator -> texelAddressGen -> textureMemory -> texel
//
// No back-pressure, the pipeline always drains
module textureSampler
(
    input  logic                                  aclk,
    input  logic                                  rstN,

    // Fragment requests, one-cycle strobe
    input  logic                                  reqValid,
    input  texPipePkg::texRequest_t               req,

    // Memory load port
    input  logic                                  memWrite,
    input  logic [texConfigPkg::memAddrWidth-1:0] memAddr,
    input  logic [texConfigPkg::texelWidth-1:0]   memData,

    // Results in request order
    output logic                                  texelValid,
    output texPipePkg::texResult_t                texel
);
    import texPipePkg::*;

    // LOD stage to address stage
    logic lodValid;
    lodStage_t lodOut;

    // Address stage to memory
    logic addrValid;
    texResult_t addrOut;

    // Stage 1, raw LOD
    lodCalculator lodCalc
    (
        .aclk(aclk),
        .rstN(rstN),
        .reqValid(reqValid),
        .req(req),
        .lodValid(lodValid),
        .lodOut(lodOut)
    );

    // Stage 2, level, wrap and chain address
    texelAddressGen addrGen
    (
        .aclk(aclk),
        .rstN(rstN),
        .lodValid(lodValid),
        .lodIn(lodOut),
        .addrValid(addrValid),
        .addrOut(addrOut)
    );

    // Stage 3, texel read
    textureMemory texMem
    (
        .aclk(aclk),
        .rstN(rstN),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memData(memData),
        .addrValid(addrValid),
        .addrIn(addrOut),
        .texelValid(texelValid),
        .texel(texel)
    );

endmodule

// File: test/textureSamplerTb.sv
`timescale 1ns/1ps

module textureSamplerTb;
    import texConfigPkg::*;
    import texPipePkg::*;

    // One row of the stimulus table
    typedef struct packed
    {
        texRequest_t req;
        logic [3:0] gap;
        texResult_t exp;
    } vector_t;

    // Outstanding request and the cycle it was strobed in
    typedef struct packed
    {
        texResult_t exp;
        logic [31:0] sendCycle;
    } pending_t;

    logic aclk;
    logic rstN;
    logic reqValid;
    texRequest_t req;
    logic memWrite;
    logic [memAddrWidth-1:0] memAddr;
    logic [texelWidth-1:0] memData;
    logic texelValid;
    texResult_t texel;

    logic [texelWidth-1:0] memCopy [2**memAddrWidth];
    vector_t vectors[$];
    pending_t expQ[$];
    pending_t head;
    int cycleCount = 0;
    int valueErrors = 0;
    int otherErrors = 0;

    textureSampler uut
    (
        .aclk(aclk),
        .rstN(rstN),
        .reqValid(reqValid),
        .req(req),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memData(memData),
        .texelValid(texelValid),
        .texel(texel)
    );

    always #50 aclk = ~aclk;

    always @(posedge aclk)
        cycleCount <= cycleCount + 1;

    function automatic fixed_t fromReal(input real x);
        return fixed_t'($rtoi(x * 32768.0));
    endfunction

    // Side log2 of a mip level never drops below one texel
    function automatic int sideAtLevel(input int sizeLog2, input int level);
        return (sizeLog2 > level) ? sizeLog2 - level : 0;
    endfunction

    // Texel index along one axis after wrapping
    function automatic int axisIndex(input fixed_t c, input wrapMode_t mode, input int sizeLog2);
        int idx;
        // Top fraction bits give the repeat result
        idx = int'(c[14:0]) >> (15 - sizeLog2);
        if (mode == wrapClamp && c < 0)
            idx = 0;
        else if (mode == wrapClamp && c >= 32'sd32768)
            idx = (1 << sizeLog2) - 1;
        return idx;
    endfunction

    // Expected level, address and data for one request
    function automatic texResult_t modelFetch(input texRequest_t r);
        longint dS;
        longint dT;
        int stepBits;
        int lod;
        int w;
        int h;
        int level;
        int base;
        texResult_t res;
        dS = longint'($signed(r.s)) - longint'($signed(r.sXy));
        dT = longint'($signed(r.t)) - longint'($signed(r.tXy));
        dS = (dS < 0) ? -dS : dS;
        dT = (dT < 0) ? -dT : dT;
        w = int'(r.cfg.widthLog2);
        h = int'(r.cfg.heightLog2);
        // Fraction bits 14..7 of each step scaled to texels of level 0
        stepBits = (int'((dS >> 7) & 255) >> (8 - w)) | (int'((dT >> 7) & 255) >> (8 - h));
        lod = 0;
        for (int b = 0; b < 8; b++)
            if (stepBits[b])
                lod = b + 1;
        level = (w > h) ? w : h;
        level = (lod < level) ? lod : level;
        // Word counts of all smaller level numbers
        base = 0;
        for (int k = 0; k < level; k++)
            base += (1 << sideAtLevel(w, k)) * (1 << sideAtLevel(h, k));
        base += axisIndex(r.t, r.cfg.wrapT, sideAtLevel(h, level)) << sideAtLevel(w, level);
        base += axisIndex(r.s, r.cfg.wrapS, sideAtLevel(w, level));
        res.level = 4'(level);
        res.addr = memAddrWidth'(base);
        res.data = memCopy[res.addr];
        return res;
    endfunction

    task automatic addEntry(input real s, input real t, input real ds, input real dt,
                            input int wl, input int hl, input int ws, input int wt, input int gap);
        vector_t vec;
        vec = '0;
        vec.req.s = fromReal(s);
        vec.req.t = fromReal(t);
        vec.req.sXy = fromReal(s + ds);
        vec.req.tXy = fromReal(t + dt);
        vec.req.cfg.widthLog2 = 4'(wl);
        vec.req.cfg.heightLog2 = 4'(hl);
        vec.req.cfg.wrapS = wrapMode_t'(ws);
        vec.req.cfg.wrapT = wrapMode_t'(wt);
        vec.gap = 4'(gap);
        vectors.push_back(vec);
    endtask

    task automatic checkField(input string name, input logic [31:0] expV, input logic [31:0] actV);
        assert (actV === expV)
        else
        begin
            valueErrors++;
            $display("** Error: %s expected %h actual %h", name, expV, actV);
        end
    endtask

    task automatic checkIdle(input int cycles);
        repeat (cycles)
        begin
            @(negedge aclk);
            checkField("texelValid", 32'd0, 32'(texelValid));
        end
    endtask

    task automatic writeWord(input int a, input logic [texelWidth-1:0] d);
        @(negedge aclk);
        memWrite = 1'b1;
        memAddr = memAddrWidth'(a);
        memData = d;
        memCopy[a] = d;
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(negedge aclk);
            reqValid = 1'b0;
            memWrite = 1'b0;
        end
    endtask

    task automatic sendRequest(input texRequest_t r, input texResult_t e);
        pending_t p;
        @(negedge aclk);
        reqValid = 1'b1;
        req = r;
        p.exp = e;
        p.sendCycle = cycleCount;
        expQ.push_back(p);
    endtask

    // Compare each result with the oldest outstanding request
    always @(negedge aclk)
    begin
        if (texelValid === 1'b1)
        begin
            assert (expQ.size() != 0)
            else
            begin
                otherErrors++;
                $display("A result arrived while no request was outstanding");
            end
            if (expQ.size() != 0)
            begin
                head = expQ.pop_front();
                checkField("texel.level", 32'(head.exp.level), 32'(texel.level));
                checkField("texel.addr", 32'(head.exp.addr), 32'(texel.addr));
                checkField("texel.data", 32'(head.exp.data), 32'(texel.data));
                // Strobe to result is three clocks
                assert (cycleCount - head.sendCycle == 3)
                else
                begin
                    otherErrors++;
                    $display("Result for address %h came %0d cycles after its request, not 3",
                             texel.addr, cycleCount - head.sendCycle);
                end
            end
        end
    end

    initial
    begin
        int waited;
        texRequest_t again;
        aclk = 1'b0;
        rstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        memWrite = 1'b0;
        memAddr = '0;
        memData = '0;
        void'($urandom(32'h95c736f5));

        // Four clocks of reset, then ten quiet clocks
        checkIdle(4);
        rstN = 1'b1;
        checkIdle(10);

        for (int a = 0; a < 2**memAddrWidth; a++)
            writeWord(a, texelWidth'($urandom));
        idleCycles(1);

        // LOD 0..5 on 32x32 plus a t-only step and a step whose integer part drops out
        addEntry(0.3, 0.6, 0.0, 0.0, 5, 5, 0, 0, 0);
        for (int k = 0; k < 5; k++)
            addEntry(0.3, 0.6, real'(1 << k) / 32.0, 0.0, 5, 5, 0, 0, 0);
        addEntry(0.1, 0.9, 0.0, -0.25, 5, 5, 0, 0, 1);
        addEntry(0.1, 0.9, 1.5, 0.0, 5, 5, 0, 0, 0);
        addEntry(0.4, 0.4, 0.5, 0.5, 2, 2, 0, 0, 2);
        // Wrap on 8x8 with each axis alone under repeat and clamp
        addEntry(-0.25, 0.5, 0.0, 0.0, 3, 3, 0, 0, 0);
        addEntry(-0.25, 0.5, 0.0, 0.0, 3, 3, 1, 0, 0);
        addEntry(1.25, 0.5, 0.0, 0.0, 3, 3, 0, 0, 0);
        addEntry(1.25, 0.5, 0.0, 0.0, 3, 3, 1, 0, 3);
        addEntry(0.5, -0.75, 0.0, 0.0, 3, 3, 0, 0, 0);
        addEntry(0.5, -0.75, 0.0, 0.0, 3, 3, 0, 1, 0);
        addEntry(0.5, 2.125, 0.0, 0.0, 3, 3, 0, 0, 0);
        addEntry(0.5, 2.125, 0.0, 0.0, 3, 3, 0, 1, 0);
        addEntry(0.625, 0.375, 0.0, 0.0, 3, 3, 1, 1, 1);
        // 32x4 and 1x16 chains at every level
        for (int k = 0; k < 6; k++)
            addEntry(0.7, 0.3, (k == 0) ? 0.0 : real'(1 << (k - 1)) / 32.0, 0.0, 5, 2, 0, 0, k % 2);
        for (int k = 0; k < 5; k++)
            addEntry(0.7, 0.3, 0.0, (k == 0) ? 0.0 : real'(1 << (k - 1)) / 16.0, 0, 4, 0, 0, 0);
        addEntry(-3.5, 7.25, 0.5, 0.5, 0, 0, 1, 0, 0);

        foreach (vectors[i])
            vectors[i].exp = modelFetch(vectors[i].req);
        foreach (vectors[i])
        begin
            sendRequest(vectors[i].req, vectors[i].exp);
            idleCycles(int'(vectors[i].gap));
        end
        idleCycles(1);

        // New word at a fetched address must be seen by the next fetch
        again = vectors[0].req;
        writeWord(int'(vectors[0].exp.addr), ~memCopy[vectors[0].exp.addr]);
        idleCycles(1);
        sendRequest(again, modelFetch(again));
        idleCycles(1);

        waited = 0;
        while (expQ.size() != 0 && waited < 50)
        begin
            @(negedge aclk);
            waited++;
        end
        assert (expQ.size() == 0)
        else
        begin
            otherErrors++;
            $display("Timed out with %0d results still outstanding", expQ.size());
        end

        $display("Errors: %0d wrong values, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sources.f
hdl/texConfigPkg.sv
hdl/texPipePkg.sv
hdl/lodCalculator.sv
hdl/texelAddressGen.sv
hdl/textureMemory.sv
hdl/textureSampler.sv
test/textureSamplerTb.sv

// File: run.sh
#!/bin/sh
# Build the sampler testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module textureSamplerTb -o textureSamplerSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/textureSamplerSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
